// File: common/sliceTypesPkg.sv
package sliceTypesPkg;

    // Word geometry
    localparam int SLICE_WIDTH    = 4;
    localparam int NUM_SLICES     = 4;
    localparam int DATA_WIDTH     = SLICE_WIDTH * NUM_SLICES;
    // Sixteen words per slice
    localparam int REG_ADDR_WIDTH = 4;

    // Source operand pair, R first then S
    typedef enum logic [2:0] {
        AQ = 3'd0,
        AB = 3'd1,
        ZQ = 3'd2,
        ZB = 3'd3,
        ZA = 3'd4,
        DA = 3'd5,
        DQ = 3'd6,
        DZ = 3'd7
    } aluSrc_e;

    // ALU function
    typedef enum logic [2:0] {
        ADD   = 3'd0,
        SUBR  = 3'd1,   // S minus R
        SUBS  = 3'd2,   // R minus S
        OR    = 3'd3,
        AND   = 3'd4,
        NOTRS = 3'd5,   // not R, and S
        EXOR  = 3'd6,
        EXNOR = 3'd7
    } aluFunc_e;

    // Destination and shift control
    typedef enum logic [2:0] {
        QREG  = 3'd0,   // F into Q
        NOP   = 3'd1,
        RAMA  = 3'd2,   // F into RAM, Y shows A
        RAMF  = 3'd3,
        RAMQD = 3'd4,   // RAM and Q shift down
        RAMD  = 3'd5,
        RAMQU = 3'd6,   // RAM and Q shift up
        RAMU  = 3'd7
    } aluDest_e;

    // Nine-bit microinstruction, dest in the top bits
    typedef struct packed {
        aluDest_e dest;
        aluFunc_e func;
        aluSrc_e  src;
    } microInstr_t;

    // End-of-word serial linkage for the shifters
    typedef enum logic [1:0] {
        ZERO   = 2'd0,
        ROTATE = 2'd1,
        ARITH  = 2'd2,
        DOUBLE = 2'd3   // RAM and Q as one 32-bit register
    } shiftMode_e;

    // Per-slice ALU status
    typedef struct packed {
        logic carryOut;
        logic gBar;
        logic pBar;
        logic overflow;
        logic f3;
        logic fZero;
    } sliceFlags_t;

    // Whole-word status
    typedef struct packed {
        logic carry;
        logic overflow;
        logic sign;
        logic zero;
    } wordStatus_t;

endpackage

// File: bitSlice/sliceAlu.sv
`timescale 1ns/1ps

module sliceAlu (
    input  sliceTypesPkg::microInstr_t                 instr,
    input  logic [sliceTypesPkg::SLICE_WIDTH-1:0]      a,
    input  logic [sliceTypesPkg::SLICE_WIDTH-1:0]      b,
    input  logic [sliceTypesPkg::SLICE_WIDTH-1:0]      d,
    input  logic [sliceTypesPkg::SLICE_WIDTH-1:0]      q,
    input  logic                                       carryIn,
    output logic [sliceTypesPkg::SLICE_WIDTH-1:0]      f,
    output sliceTypesPkg::sliceFlags_t                 flags
);

    import sliceTypesPkg::*;

    logic [SLICE_WIDTH-1:0] rOp;
    logic [SLICE_WIDTH-1:0] sOp;
    // One extra top bit so the add leaves its carry there
    logic [SLICE_WIDTH:0]   rExt;
    logic [SLICE_WIDTH:0]   sExt;
    logic [SLICE_WIDTH:0]   result;
    logic [SLICE_WIDTH-1:0] pTerm;
    logic [SLICE_WIDTH-1:0] gTerm;
    logic                   groupGen;

    // Operand pair from the source code
    always_comb begin
        unique case (instr.src)
            AQ: begin rOp = a; sOp = q; end
            AB: begin rOp = a; sOp = b; end
            ZQ: begin rOp = '0; sOp = q; end
            ZB: begin rOp = '0; sOp = b; end
            ZA: begin rOp = '0; sOp = a; end
            DA: begin rOp = d; sOp = a; end
            DQ: begin rOp = d; sOp = q; end
            default: begin rOp = d; sOp = '0; end
        endcase
    end

    // Subtraction inverts one side, carryIn supplies the +1
    assign rExt = (instr.func == SUBR) ? {1'b0, ~rOp} : {1'b0, rOp};
    assign sExt = (instr.func == SUBS) ? {1'b0, ~sOp} : {1'b0, sOp};

    always_comb begin
        unique case (instr.func)
            ADD, SUBR, SUBS: result = rExt + sExt + (SLICE_WIDTH+1)'(carryIn);
            OR:              result = rExt | sExt;
            AND:             result = rExt & sExt;
            NOTRS:           result = ~rExt & sExt;
            EXOR:            result = rExt ^ sExt;
            default:         result = ~rExt ^ sExt;
        endcase
    end

    assign f = result[SLICE_WIDTH-1:0];

    // Lookahead terms on the possibly inverted operands
    assign pTerm = rExt[SLICE_WIDTH-1:0] | sExt[SLICE_WIDTH-1:0];
    assign gTerm = rExt[SLICE_WIDTH-1:0] & sExt[SLICE_WIDTH-1:0];

    // Standard four-term group generate
    assign groupGen = gTerm[3]
                    | (pTerm[3] & gTerm[2])
                    | (pTerm[3] & pTerm[2] & gTerm[1])
                    | (pTerm[3] & pTerm[2] & pTerm[1] & gTerm[0]);

    always_comb begin
        flags.carryOut = result[SLICE_WIDTH];
        flags.gBar     = ~groupGen;
        flags.pBar     = ~(&pTerm);
        // Operand signs agree but result sign differs
        flags.overflow = ~(rExt[SLICE_WIDTH-1] ^ sExt[SLICE_WIDTH-1])
                       & (rExt[SLICE_WIDTH-1] ^ result[SLICE_WIDTH-1]);
        flags.f3       = result[SLICE_WIDTH-1];
        flags.fZero    = ~(|result[SLICE_WIDTH-1:0]);
    end

endmodule

// File: bitSlice/bitSlice.sv
`timescale 1ns/1ps

module bitSlice (
    input  logic                                        CLK,
    input  logic                                        reset,
    input  sliceTypesPkg::microInstr_t                  instr,
    input  logic [sliceTypesPkg::REG_ADDR_WIDTH-1:0]    aAddr,
    input  logic [sliceTypesPkg::REG_ADDR_WIDTH-1:0]    bAddr,
    input  logic [sliceTypesPkg::SLICE_WIDTH-1:0]       d,
    input  logic                                        carryIn,
    input  logic                                        ram0In,
    input  logic                                        ram3In,
    input  logic                                        q0In,
    input  logic                                        q3In,
    output logic [sliceTypesPkg::SLICE_WIDTH-1:0]       y,
    output logic                                        ram0Out,
    output logic                                        ram3Out,
    output logic                                        q0Out,
    output logic                                        q3Out,
    output sliceTypesPkg::sliceFlags_t                  flags
);

    import sliceTypesPkg::*;

    localparam int NUM_WORDS = 2 ** REG_ADDR_WIDTH;

    // Two read ports, one write port on bAddr
    logic [SLICE_WIDTH-1:0] regFile [NUM_WORDS];
    logic [SLICE_WIDTH-1:0] qReg;
    logic [SLICE_WIDTH-1:0] aData;
    logic [SLICE_WIDTH-1:0] bData;
    logic [SLICE_WIDTH-1:0] f;

    assign aData = regFile[aAddr];
    assign bData = regFile[bAddr];

    sliceAlu i_sliceAlu (
        .instr   (instr),
        .a       (aData),
        .b       (bData),
        .d       (d),
        .q       (qReg),
        .carryIn (carryIn),
        .f       (f),
        .flags   (flags)
    );

    // RAM write, plain or through the up/down shifter
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            case (instr.dest)
                RAMA, RAMF:   regFile[bAddr] <= f;
                // Down shift, upper neighbour feeds the top bit
                RAMQD, RAMD:  regFile[bAddr] <= {ram3In, f[SLICE_WIDTH-1:1]};
                // Up shift, lower neighbour feeds bit 0
                RAMQU, RAMU:  regFile[bAddr] <= {f[SLICE_WIDTH-2:0], ram0In};
                default: ;
            endcase
        end
    end

    // Q load and shift
    always_ff @(posedge CLK) begin
        if (reset) begin
            qReg <= '0;
        end else begin
            case (instr.dest)
                QREG:    qReg <= f;
                RAMQD:   qReg <= {q3In, qReg[SLICE_WIDTH-1:1]};
                RAMQU:   qReg <= {qReg[SLICE_WIDTH-2:0], q0In};
                default: ;
            endcase
        end
    end

    // A bypasses to Y only for RAMA
    assign y = (instr.dest == RAMA) ? aData : f;

    // Serial out-bits for the neighbouring slices
    assign ram0Out = f[0];
    assign ram3Out = f[SLICE_WIDTH-1];
    assign q0Out   = qReg[0];
    assign q3Out   = qReg[SLICE_WIDTH-1];

endmodule

// File: hdl/carryLookahead.sv
`timescale 1ns/1ps

module carryLookahead (
    input  logic                                    carryIn,
    input  logic [sliceTypesPkg::NUM_SLICES-1:0]    gBar,
    input  logic [sliceTypesPkg::NUM_SLICES-1:0]    pBar,
    output logic [sliceTypesPkg::NUM_SLICES-2:0]    sliceCarry,
    output logic                                    carryOut
);

    logic [sliceTypesPkg::NUM_SLICES-1:0] g;
    logic [sliceTypesPkg::NUM_SLICES-1:0] p;

    // Slices report active-low terms
    assign g = ~gBar;
    assign p = ~pBar;

    // Carry into slice 1
    assign sliceCarry[0] = g[0] | (p[0] & carryIn);

    // Carry into slice 2
    assign sliceCarry[1] = g[1]
                         | (p[1] & g[0])
                         | (p[1] & p[0] & carryIn);

    // Carry into slice 3
    assign sliceCarry[2] = g[2]
                         | (p[2] & g[1])
                         | (p[2] & p[1] & g[0])
                         | (p[2] & p[1] & p[0] & carryIn);

    // Word carry out, still flat
    assign carryOut = g[3]
                    | (p[3] & g[2])
                    | (p[3] & p[2] & g[1])
                    | (p[3] & p[2] & p[1] & g[0])
                    | (p[3] & p[2] & p[1] & p[0] & carryIn);

endmodule

// File: hdl/shiftLinkage.sv
`timescale 1ns/1ps

module shiftLinkage (
    input  sliceTypesPkg::shiftMode_e   shiftMode,
    input  sliceTypesPkg::aluDest_e     dest,
    input  logic                        ramLowOut,
    input  logic                        ramHighOut,
    input  logic                        qLowOut,
    input  logic                        qHighOut,
    input  logic                        signBit,
    output logic                        ramLowIn,
    output logic                        ramHighIn,
    output logic                        qLowIn,
    output logic                        qHighIn
);

    import sliceTypesPkg::*;

    logic shiftDown;
    logic shiftUp;

    assign shiftDown = (dest == RAMQD) || (dest == RAMD);
    assign shiftUp   = (dest == RAMQU) || (dest == RAMU);

    always_comb begin
        // Zero fill unless a mode below overrides
        ramLowIn  = 1'b0;
        ramHighIn = 1'b0;
        qLowIn    = 1'b0;
        qHighIn   = 1'b0;
        case (shiftMode)
            ROTATE: begin
                // Bit leaving one end re-enters at the other
                if (shiftDown) begin
                    ramHighIn = ramLowOut;
                    qHighIn   = qLowOut;
                end
                if (shiftUp) begin
                    ramLowIn = ramHighOut;
                    qLowIn   = qHighOut;
                end
            end
            ARITH: begin
                // Sign copy on right shift only, Q zero filled
                if (shiftDown) begin
                    ramHighIn = signBit;
                end
            end
            DOUBLE: begin
                // RAM is the upper half, Q the lower
                if (shiftDown) begin
                    qHighIn = ramLowOut;
                end
                if (shiftUp) begin
                    ramLowIn = qHighOut;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/sliceDatapath.sv
`timescale 1ns/1ps

module sliceDatapath (
    input  logic                                        CLK,
    input  logic                                        reset,
    input  sliceTypesPkg::microInstr_t                  instr,
    input  logic [sliceTypesPkg::REG_ADDR_WIDTH-1:0]    aAddr,
    input  logic [sliceTypesPkg::REG_ADDR_WIDTH-1:0]    bAddr,
    input  logic [sliceTypesPkg::DATA_WIDTH-1:0]        dataIn,
    input  logic                                        carryIn,
    input  sliceTypesPkg::shiftMode_e                   shiftMode,
    output logic [sliceTypesPkg::DATA_WIDTH-1:0]        y,
    output sliceTypesPkg::wordStatus_t                  status
);

    import sliceTypesPkg::*;

    localparam int TOP = NUM_SLICES - 1;

    sliceFlags_t            flags [NUM_SLICES];
    logic [NUM_SLICES-1:0]  gBar;
    logic [NUM_SLICES-1:0]  pBar;
    logic [NUM_SLICES-1:0]  fZero;
    logic [NUM_SLICES-2:0]  sliceCarry;
    logic [NUM_SLICES-1:0]  carryChain;
    logic                   wordCarry;

    // Serial shift bits, one per slice
    logic [NUM_SLICES-1:0]  ram0Out, ram3Out, q0Out, q3Out;
    logic [NUM_SLICES-1:0]  ram0In, ram3In, q0In, q3In;
    logic                   ramLowIn, ramHighIn, qLowIn, qHighIn;

    // Slice 0 takes the external carry
    assign carryChain = {sliceCarry, carryIn};

    // Down shift takes the upper neighbour's bit 0, up shift the lower's bit 3
    assign ram3In = {ramHighIn, ram0Out[TOP:1]};
    assign q3In   = {qHighIn, q0Out[TOP:1]};
    assign ram0In = {ram3Out[TOP-1:0], ramLowIn};
    assign q0In   = {q3Out[TOP-1:0], qLowIn};

    for (genvar k = 0; k < NUM_SLICES; k++) begin : g_slice
        bitSlice i_bitSlice (
            .CLK     (CLK),
            .reset   (reset),
            .instr   (instr),
            .aAddr   (aAddr),
            .bAddr   (bAddr),
            .d       (dataIn[k*SLICE_WIDTH +: SLICE_WIDTH]),
            .carryIn (carryChain[k]),
            .ram0In  (ram0In[k]),
            .ram3In  (ram3In[k]),
            .q0In    (q0In[k]),
            .q3In    (q3In[k]),
            .y       (y[k*SLICE_WIDTH +: SLICE_WIDTH]),
            .ram0Out (ram0Out[k]),
            .ram3Out (ram3Out[k]),
            .q0Out   (q0Out[k]),
            .q3Out   (q3Out[k]),
            .flags   (flags[k])
        );

        assign gBar[k]  = flags[k].gBar;
        assign pBar[k]  = flags[k].pBar;
        assign fZero[k] = flags[k].fZero;
    end

    carryLookahead i_carryLookahead (
        .carryIn    (carryIn),
        .gBar       (gBar),
        .pBar       (pBar),
        .sliceCarry (sliceCarry),
        .carryOut   (wordCarry)
    );

    // Word ends only, F bit 15 for the arithmetic shift
    shiftLinkage i_shiftLinkage (
        .shiftMode  (shiftMode),
        .dest       (instr.dest),
        .ramLowOut  (ram0Out[0]),
        .ramHighOut (ram3Out[TOP]),
        .qLowOut    (q0Out[0]),
        .qHighOut   (q3Out[TOP]),
        .signBit    (flags[TOP].f3),
        .ramLowIn   (ramLowIn),
        .ramHighIn  (ramHighIn),
        .qLowIn     (qLowIn),
        .qHighIn    (qHighIn)
    );

    // Status over the whole word
    assign status.carry    = wordCarry;
    assign status.overflow = flags[TOP].overflow;
    assign status.sign     = flags[TOP].f3;
    assign status.zero     = &fZero;

endmodule

// File: dv/sliceDatapathTb.sv
`timescale 1ns/1ps

module sliceDatapathTb;

    import sliceTypesPkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 10;

    // One stimulus row per cycle
    // Expected values come from the reference model
    typedef struct packed {
        microInstr_t               instr;
        logic [REG_ADDR_WIDTH-1:0] aAddr;
        logic [REG_ADDR_WIDTH-1:0] bAddr;
        logic [DATA_WIDTH-1:0]     data;
        logic                      carryIn;
        shiftMode_e                shiftMode;
    } stimRow_t;

    logic                      CLK;
    logic                      reset;
    microInstr_t               instr;
    logic [REG_ADDR_WIDTH-1:0] aAddr;
    logic [REG_ADDR_WIDTH-1:0] bAddr;
    logic [DATA_WIDTH-1:0]     dataIn;
    logic                      carryIn;
    shiftMode_e                shiftMode;
    logic [DATA_WIDTH-1:0]     y;
    wordStatus_t               status;

    stimRow_t              stimTable [$];
    int                    tableLen   = 0;
    logic [31:0]           lcgState   = 32'hfd9c_a533;
    // Reference copy of the four slices' registers and Q as full words
    logic [DATA_WIDTH-1:0] modelReg [16];
    logic [DATA_WIDTH-1:0] modelQ;

    sliceDatapath i_sliceDatapath (
        .CLK       (CLK),
        .reset     (reset),
        .instr     (instr),
        .aAddr     (aAddr),
        .bAddr     (bAddr),
        .dataIn    (dataIn),
        .carryIn   (carryIn),
        .shiftMode (shiftMode),
        .y         (y),
        .status    (status)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Upper half only since the low LCG bits have short periods
    function automatic logic [DATA_WIDTH-1:0] randData();
        logic [31:0] r;
        r = nextRand();
        return r[31:16];
    endfunction

    function automatic stimRow_t makeRow(input aluDest_e dest, input aluFunc_e func,
                                         input aluSrc_e src, input logic [3:0] a,
                                         input logic [3:0] b, input logic [15:0] data,
                                         input logic cin, input shiftMode_e mode);
        stimRow_t row;
        row.instr.dest = dest;
        row.instr.func = func;
        row.instr.src  = src;
        row.aAddr      = a;
        row.bAddr      = b;
        row.data       = data;
        row.carryIn    = cin;
        row.shiftMode  = mode;
        return row;
    endfunction

    function automatic stimRow_t randomRow();
        logic [31:0] r;
        r = nextRand();
        return makeRow(aluDest_e'(r[31:29]), aluFunc_e'(r[28:26]), aluSrc_e'(r[25:23]),
                       r[22:19], r[18:15], randData(), r[14], shiftMode_e'(r[13:12]));
    endfunction

    task automatic buildTable();
        logic [31:0] r;
        logic [3:0]  idx;
        // Everything reads as zero straight after reset
        for (int i = 0; i < 16; i++) begin
            stimTable.push_back(makeRow(NOP, OR, ZA, 4'(i), 0, randData(), 1'b0, ZERO));
        end
        // Load every register and Q and read them back
        for (int i = 0; i < 16; i++) begin
            stimTable.push_back(makeRow(RAMF, ADD, DZ, 0, 4'(i), randData(), 1'b0, ZERO));
        end
        stimTable.push_back(makeRow(QREG, ADD, DZ, 0, 0, randData(), 1'b0, ZERO));
        for (int i = 0; i < 16; i++) begin
            stimTable.push_back(makeRow(NOP, OR, ZA, 4'(i), 0, randData(), 1'b0, ZERO));
        end
        stimTable.push_back(makeRow(NOP, OR, ZQ, 0, 0, randData(), 1'b0, ZERO));
        // Y shows A while F is written
        for (int i = 0; i < 4; i++) begin
            stimTable.push_back(makeRow(RAMA, ADD, DA, 4'(i), 4'(i + 5), randData(),
                                        1'(i), ZERO));
        end
        // Registers written through RAMA
        for (int i = 0; i < 4; i++) begin
            stimTable.push_back(makeRow(NOP, OR, ZA, 4'(i + 5), 0, randData(), 1'b0, ZERO));
        end
        // Corner rows for overflow, carry and zero
        stimTable.push_back(makeRow(RAMF, ADD, DZ, 0, 0, 16'h7fff, 1'b0, ZERO));
        stimTable.push_back(makeRow(QREG, OR, DZ, 0, 0, 16'h0001, 1'b0, ZERO));
        stimTable.push_back(makeRow(NOP, ADD, AQ, 0, 0, 16'h0000, 1'b0, ZERO));
        stimTable.push_back(makeRow(NOP, ADD, DZ, 0, 0, 16'hffff, 1'b1, ZERO));
        stimTable.push_back(makeRow(NOP, SUBS, DA, 0, 0, 16'h7fff, 1'b1, ZERO));
        stimTable.push_back(makeRow(NOP, SUBR, DA, 0, 0, 16'h0000, 1'b1, ZERO));
        // Arithmetic on random operands with both carry-in values
        for (int i = 0; i < 48; i++) begin
            r = nextRand();
            stimTable.push_back(makeRow((i % 4 == 1) ? RAMF : ((i % 4 == 2) ? QREG : NOP),
                                        aluFunc_e'(3'(i % 3)), aluSrc_e'(r[31:29]),
                                        r[27:24], r[23:20], randData(), 1'((i / 3) % 2),
                                        ZERO));
        end
        // Logic functions over all source pairs
        for (int f = 3; f < 8; f++) begin
            for (int s = 0; s < 8; s++) begin
                r = nextRand();
                stimTable.push_back(makeRow((s % 2 == 1) ? RAMF : NOP, aluFunc_e'(3'(f)),
                                            aluSrc_e'(3'(s)), r[31:28], r[27:24],
                                            randData(), r[23], ZERO));
            end
        end
        // Every shift destination in every mode shifts twice in place before readback
        for (int m = 0; m < 4; m++) begin
            for (int k = 0; k < 4; k++) begin
                idx = 4'(m * 4 + k);
                stimTable.push_back(makeRow(RAMF, OR, DZ, 0, idx, randData(), 1'b0, ZERO));
                stimTable.push_back(makeRow(QREG, OR, DZ, 0, 0, randData(), 1'b0, ZERO));
                repeat (2) begin
                    stimTable.push_back(makeRow(aluDest_e'(3'(k + 4)), OR, ZB, idx, idx,
                                                randData(), 1'b0, shiftMode_e'(2'(m))));
                end
                stimTable.push_back(makeRow(NOP, OR, ZA, idx, 0, randData(), 1'b0, ZERO));
                stimTable.push_back(makeRow(NOP, OR, ZQ, 0, 0, randData(), 1'b0, ZERO));
            end
        end
        // Fully random tail
        for (int i = 0; i < 40; i++) begin
            stimTable.push_back(randomRow());
        end
    endtask

    // Expected y and status from the full-word two's-complement rules
    task automatic evaluate(input stimRow_t row, output logic [15:0] expY,
                            output wordStatus_t expStatus, output logic [15:0] expF);
        logic [15:0] aVal;
        logic [15:0] bVal;
        logic [15:0] rOp;
        logic [15:0] sOp;
        logic [15:0] rIn;
        logic [15:0] sIn;
        logic [16:0] sum;
        aVal = modelReg[row.aAddr];
        bVal = modelReg[row.bAddr];
        case (row.instr.src)
            AQ: begin rOp = aVal; sOp = modelQ; end
            AB: begin rOp = aVal; sOp = bVal; end
            ZQ: begin rOp = '0; sOp = modelQ; end
            ZB: begin rOp = '0; sOp = bVal; end
            ZA: begin rOp = '0; sOp = aVal; end
            DA: begin rOp = row.data; sOp = aVal; end
            DQ: begin rOp = row.data; sOp = modelQ; end
            default: begin rOp = row.data; sOp = '0; end
        endcase
        rIn = (row.instr.func == SUBR) ? ~rOp : rOp;
        sIn = (row.instr.func == SUBS) ? ~sOp : sOp;
        sum = {1'b0, rIn} + {1'b0, sIn} + 17'(row.carryIn);
        case (row.instr.func)
            OR:      expF = rIn | sIn;
            AND:     expF = rIn & sIn;
            NOTRS:   expF = ~rIn & sIn;
            EXOR:    expF = rIn ^ sIn;
            EXNOR:   expF = ~rIn ^ sIn;
            default: expF = sum[15:0];
        endcase
        // Lookahead carry always follows the extended add of R and S
        expStatus.carry    = sum[16];
        expStatus.overflow = ~(rIn[15] ^ sIn[15]) & (rIn[15] ^ expF[15]);
        expStatus.sign     = expF[15];
        expStatus.zero     = (expF == 16'h0000);
        expY = (row.instr.dest == RAMA) ? aVal : expF;
    endtask

    // Model state update at the clock edge
    // End bits come from the shift linkage
    task automatic commit(input stimRow_t row, input logic [15:0] fVal);
        logic down;
        logic up;
        logic ramLowIn;
        logic ramHighIn;
        logic qLowIn;
        logic qHighIn;
        down      = (row.instr.dest == RAMQD) || (row.instr.dest == RAMD);
        up        = (row.instr.dest == RAMQU) || (row.instr.dest == RAMU);
        ramLowIn  = 1'b0;
        ramHighIn = 1'b0;
        qLowIn    = 1'b0;
        qHighIn   = 1'b0;
        case (row.shiftMode)
            ROTATE: begin
                ramHighIn = down & fVal[0];
                qHighIn   = down & modelQ[0];
                ramLowIn  = up & fVal[15];
                qLowIn    = up & modelQ[15];
            end
            ARITH:  ramHighIn = down & fVal[15];
            // RAM above Q as one 32-bit register
            DOUBLE: begin
                qHighIn  = down & fVal[0];
                ramLowIn = up & modelQ[15];
            end
            default: ;
        endcase
        case (row.instr.dest)
            QREG:       modelQ = fVal;
            RAMA, RAMF: modelReg[row.bAddr] = fVal;
            RAMD:       modelReg[row.bAddr] = {ramHighIn, fVal[15:1]};
            RAMU:       modelReg[row.bAddr] = {fVal[14:0], ramLowIn};
            RAMQD: begin
                modelReg[row.bAddr] = {ramHighIn, fVal[15:1]};
                modelQ              = {qHighIn, modelQ[15:1]};
            end
            RAMQU: begin
                modelReg[row.bAddr] = {fVal[14:0], ramLowIn};
                modelQ              = {modelQ[14:0], qLowIn};
            end
            default: ;
        endcase
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    initial begin
        stimRow_t    row;
        logic [15:0] expY;
        logic [15:0] expF;
        wordStatus_t expStatus;
        reset     = 1'b1;
        instr     = '0;
        aAddr     = '0;
        bAddr     = '0;
        dataIn    = '0;
        carryIn   = 1'b0;
        shiftMode = ZERO;
        modelQ    = '0;
        for (int i = 0; i < 16; i++) begin
            modelReg[i] = '0;
        end
        buildTable();
        tableLen = stimTable.size();
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        reset = 1'b0;
        foreach (stimTable[i]) begin
            row       = stimTable[i];
            instr     = row.instr;
            aAddr     = row.aAddr;
            bAddr     = row.bAddr;
            dataIn    = row.data;
            carryIn   = row.carryIn;
            shiftMode = row.shiftMode;
            // Sample mid-cycle away from both edges
            #(CLK_PERIOD / 2);
            evaluate(row, expY, expStatus, expF);
            checkValue("y", y, expY);
            checkValue("status", status, expStatus);
            commit(row, expF);
            @(posedge CLK);
            #DRIVE_DELAY;
        end
        $display("Verification passed");
        $finish;
    end

    // Ten clock periods per row plus the reset
    initial begin
        wait (tableLen > 0);
        #((tableLen + RESET_CYCLES) * 10 * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in time");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: list.f
common/sliceTypesPkg.sv
bitSlice/sliceAlu.sv
bitSlice/bitSlice.sv
hdl/carryLookahead.sv
hdl/shiftLinkage.sv
hdl/sliceDatapath.sv
dv/sliceDatapathTb.sv

// File: Bender.yml
package:
  name: slice_datapath

sources:
  - common/sliceTypesPkg.sv
  - bitSlice/sliceAlu.sv
  - bitSlice/bitSlice.sv
  - hdl/carryLookahead.sv
  - hdl/shiftLinkage.sv
  - hdl/sliceDatapath.sv
  - target: test
    files:
      - dv/sliceDatapathTb.sv
